//--- logic/rfi_pkg.sv
package rfi_pkg;

    // Input sample and channel layout.
    localparam int DIN_WIDTH = 8;
    localparam int CHANNEL_ADDR = 3;

    // Datapath widths.
    localparam int POW_WIDTH = 17;
    localparam int ACC_WIDTH = 24;
    localparam int POST_ACC_SHIFT = 8;
    localparam int CAST_WIDTH = 12;
    localparam int DOUT_SHIFT = 8;
    localparam int DOUT_WIDTH = 16;
    localparam int ACC_LEN_WIDTH = 8;

    localparam int POWER_LATENCY = 2; // Cycles through complex_power.

    typedef logic signed [DIN_WIDTH-1:0] sample_t;
    typedef logic [POW_WIDTH-1:0] power_t;
    typedef logic [ACC_WIDTH-1:0] acc_t;
    typedef logic [CAST_WIDTH-1:0] cast_t;
    typedef logic [DOUT_WIDTH-1:0] dout_t;
    typedef logic [CHANNEL_ADDR-1:0] chan_t;
    typedef logic [ACC_LEN_WIDTH-1:0] acc_len_t;

    typedef enum logic [1:0] {
        WAIT_SYNC,
        FIRST_SPEC,
        ACCUM
    } ctrl_state_t;

endpackage

//--- logic/pow_if.sv
`timescale 1ns/10ps

interface pow_if import rfi_pkg::*; ();
    power_t sig_pow;
    power_t ref_pow;
    logic valid;
    chan_t chan;     // Combinational, same beat as valid.
    logic new_acc;

    modport source (output sig_pow, ref_pow, valid);
    modport ctrl (input valid, output chan, new_acc);
    modport sink (input sig_pow, ref_pow, valid, chan, new_acc);
endinterface

//--- logic/complex_power.sv
`timescale 1ns/10ps

module complex_power import rfi_pkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  sample_t sig_re,
    input  sample_t sig_im,
    input  sample_t ref_re,
    input  sample_t ref_im,
    input  logic    din_valid,
    pow_if.source   pw
);

    sample_t sig_re_q, sig_im_q, ref_re_q, ref_im_q;
    logic valid_q;

    function automatic power_t mag_sq(sample_t re, sample_t im);
        logic signed [POW_WIDTH-1:0] re_ext;
        logic signed [POW_WIDTH-1:0] im_ext;
        re_ext = re;
        im_ext = im;
        mag_sq = power_t'(re_ext * re_ext + im_ext * im_ext); // At most 2^15.
    endfunction

    always_ff @(posedge clk) begin
        sig_re_q <= sig_re;
        sig_im_q <= sig_im;
        ref_re_q <= ref_re;
        ref_im_q <= ref_im;
        pw.sig_pow <= mag_sq(sig_re_q, sig_im_q);
        pw.ref_pow <= mag_sq(ref_re_q, ref_im_q);
        if (rst) begin
            valid_q <= 1'b0;
            pw.valid <= 1'b0;
        end else begin
            valid_q <= din_valid;
            pw.valid <= valid_q;
        end
    end

endmodule

//--- logic/spectrum_counter.sv
`timescale 1ns/10ps

module spectrum_counter import rfi_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  logic     clear,
    input  logic     count_en,
    input  acc_len_t len,
    output chan_t    chan,
    output logic     last_chan,
    output logic     last_spec
);

    chan_t    chan_cnt;
    acc_len_t spec_cnt;

    assign chan = chan_cnt;
    assign last_chan = (chan_cnt == chan_t'('1));
    // len is never zero here.
    assign last_spec = (spec_cnt == acc_len_t'(len - 1'b1));

    always_ff @(posedge clk) begin
        if (rst || clear) begin
            chan_cnt <= '0;
            spec_cnt <= '0;
        end else if (count_en) begin
            chan_cnt <= chan_cnt + 1'b1; // Wraps after the last channel.
            if (last_chan) begin
                if (last_spec) begin
                    spec_cnt <= '0;
                end else begin
                    spec_cnt <= spec_cnt + 1'b1;
                end
            end
        end
    end

endmodule

//--- logic/acc_control.sv
`timescale 1ns/10ps

module acc_control import rfi_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  logic     sync_in,
    input  logic     cnt_rst,
    input  acc_len_t acc_len,
    pow_if.ctrl      pw
);

    ctrl_state_t state;
    logic [POWER_LATENCY-1:0] sync_sr;
    logic sync_dly;
    acc_len_t len_q;
    acc_len_t len_next;
    logic count_en;
    logic clear;
    logic last_chan;
    logic last_spec;
    logic spec_done;

    // Sync follows the samples through the power stage.
    assign sync_dly = sync_sr[POWER_LATENCY-1];

    assign len_next = (acc_len == '0) ? acc_len_t'(1) : acc_len; // Zero means one.
    assign count_en = pw.valid && (state != WAIT_SYNC);
    assign clear = cnt_rst || (state == WAIT_SYNC);
    assign spec_done = count_en && last_chan;
    assign pw.new_acc = pw.valid && (state == FIRST_SPEC);

    always_ff @(posedge clk) begin
        if (rst) begin
            sync_sr <= '0;
            state <= WAIT_SYNC;
            len_q <= acc_len_t'(1);
        end else begin
            sync_sr <= {sync_sr[POWER_LATENCY-2:0], sync_in};
            if (cnt_rst) begin
                state <= WAIT_SYNC;
            end else begin
                case (state)
                    WAIT_SYNC: if (sync_dly) begin
                        state <= FIRST_SPEC;
                        len_q <= len_next;
                    end
                    FIRST_SPEC: if (spec_done) begin
                        state <= last_spec ? FIRST_SPEC : ACCUM;
                        if (last_spec) len_q <= len_next;
                    end
                    ACCUM: if (spec_done && last_spec) begin
                        state <= FIRST_SPEC;
                        len_q <= len_next;
                    end
                    default: state <= WAIT_SYNC;
                endcase
            end
        end
    end

    spectrum_counter i_spectrum_counter (
        .clk       (clk),
        .rst       (rst),
        .clear     (clear),
        .count_en  (count_en),
        .len       (len_q),
        .chan      (pw.chan),
        .last_chan (last_chan),
        .last_spec (last_spec)
    );

endmodule

//--- logic/vector_accumulator.sv
`timescale 1ns/10ps

module vector_accumulator import rfi_pkg::*; (
    input  logic clk,
    input  logic rst,
    input  logic cnt_rst,
    pow_if.sink  pw,
    output acc_t sig_acc,
    output acc_t ref_acc,
    output logic acc_valid
);

    localparam int VECTOR_LEN = 2**CHANNEL_ADDR;

    acc_t sig_mem [VECTOR_LEN];
    acc_t ref_mem [VECTOR_LEN];
    logic primed;
    acc_t sig_ext;
    acc_t ref_ext;

    assign sig_ext = acc_t'(pw.sig_pow);
    assign ref_ext = acc_t'(pw.ref_pow);

    // Sum storage and dump path.
    always_ff @(posedge clk) begin
        if (pw.valid) begin
            if (pw.new_acc) begin
                sig_acc <= sig_mem[pw.chan]; // Previous integration.
                ref_acc <= ref_mem[pw.chan];
                sig_mem[pw.chan] <= sig_ext;
                ref_mem[pw.chan] <= ref_ext;
            end else begin
                sig_mem[pw.chan] <= sig_mem[pw.chan] + sig_ext;
                ref_mem[pw.chan] <= ref_mem[pw.chan] + ref_ext;
            end
        end
    end

    // Nothing is dumped until one full first spectrum has been loaded.
    always_ff @(posedge clk) begin
        if (rst || cnt_rst) begin
            primed <= 1'b0;
        end else if (pw.valid && pw.new_acc && (pw.chan == chan_t'('1))) begin
            primed <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            acc_valid <= 1'b0;
        end else begin
            acc_valid <= pw.valid && pw.new_acc && primed && !cnt_rst;
        end
    end

endmodule

//--- logic/power_product.sv
`timescale 1ns/10ps

module power_product import rfi_pkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  acc_t  sig_acc,
    input  acc_t  ref_acc,
    input  logic  acc_valid,
    output dout_t dout,
    output logic  dout_valid,
    output logic  warning
);

    localparam int SHIFTED_WIDTH = ACC_WIDTH - POST_ACC_SHIFT;

    logic [SHIFTED_WIDTH-1:0] sig_shift;
    logic [SHIFTED_WIDTH-1:0] ref_shift;
    logic sig_ovf;
    logic ref_ovf;

    cast_t sig_cast, ref_cast;
    logic cast_valid, cast_sat;
    logic [2*CAST_WIDTH-1:0] prod;
    logic prod_valid, prod_sat;

    assign sig_shift = sig_acc[ACC_WIDTH-1:POST_ACC_SHIFT];
    assign ref_shift = ref_acc[ACC_WIDTH-1:POST_ACC_SHIFT];
    // Any bit above the cast range means clamp.
    assign sig_ovf = |sig_shift[SHIFTED_WIDTH-1:CAST_WIDTH];
    assign ref_ovf = |ref_shift[SHIFTED_WIDTH-1:CAST_WIDTH];

    always_ff @(posedge clk) begin
        sig_cast <= sig_ovf ? cast_t'('1) : sig_shift[CAST_WIDTH-1:0];
        ref_cast <= ref_ovf ? cast_t'('1) : ref_shift[CAST_WIDTH-1:0];
        cast_sat <= sig_ovf || ref_ovf;
        prod <= sig_cast * ref_cast;
        prod_sat <= cast_sat;
        dout <= prod[DOUT_SHIFT +: DOUT_WIDTH]; // Exact fit, no overflow.
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            cast_valid <= 1'b0;
            prod_valid <= 1'b0;
            dout_valid <= 1'b0;
            warning <= 1'b0;
        end else begin
            cast_valid <= acc_valid;
            prod_valid <= cast_valid;
            dout_valid <= prod_valid;
            warning <= prod_valid && prod_sat;
        end
    end

endmodule

//--- logic/rfi_power.sv
`timescale 1ns/10ps

module rfi_power import rfi_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  sample_t  sig_re,
    input  sample_t  sig_im,
    input  sample_t  ref_re,
    input  sample_t  ref_im,
    input  logic     din_valid,
    input  logic     sync_in,
    input  acc_len_t acc_len,
    input  logic     cnt_rst,
    output dout_t    dout,
    output logic     dout_valid,
    output logic     warning
);

    acc_t sig_acc;
    acc_t ref_acc;
    logic acc_valid;
    logic product_rst;

    // Products in flight belong to the discarded integration.
    assign product_rst = rst || cnt_rst;

    pow_if pow_bus ();

    complex_power i_complex_power (
        .clk       (clk),
        .rst       (rst),
        .sig_re    (sig_re),
        .sig_im    (sig_im),
        .ref_re    (ref_re),
        .ref_im    (ref_im),
        .din_valid (din_valid),
        .pw        (pow_bus.source)
    );

    acc_control i_acc_control (
        .clk     (clk),
        .rst     (rst),
        .sync_in (sync_in),
        .cnt_rst (cnt_rst),
        .acc_len (acc_len),
        .pw      (pow_bus.ctrl)
    );

    vector_accumulator i_vector_accumulator (
        .clk       (clk),
        .rst       (rst),
        .cnt_rst   (cnt_rst),
        .pw        (pow_bus.sink),
        .sig_acc   (sig_acc),
        .ref_acc   (ref_acc),
        .acc_valid (acc_valid)
    );

    power_product i_power_product (
        .clk        (clk),
        .rst        (product_rst),
        .sig_acc    (sig_acc),
        .ref_acc    (ref_acc),
        .acc_valid  (acc_valid),
        .dout       (dout),
        .dout_valid (dout_valid),
        .warning    (warning)
    );

endmodule

//--- tb/rfi_power_checker.sv
`timescale 1ns/10ps

module rfi_power_checker (
    input logic clk,
    input logic rst,
    input logic cnt_rst,
    input logic dout_valid,
    input logic warning
);

    logic [5:0] cnt_rst_hist; // cnt_rst over the last six cycles.

    always_ff @(posedge clk) begin
        if (rst) begin
            cnt_rst_hist <= '0;
        end else begin
            cnt_rst_hist <= {cnt_rst_hist[4:0], cnt_rst};
        end
    end

    a_valid_low_after_rst: assert property (@(posedge clk) rst |=> !dout_valid)
        else $error("dout_valid was high in the cycle after rst.");

    a_warning_with_valid: assert property (@(posedge clk) warning |-> dout_valid)
        else $error("warning was high without dout_valid.");

    // Products in flight are dropped by cnt_rst.
    a_quiet_after_cnt_rst: assert property (
        @(posedge clk) disable iff (rst) (|cnt_rst_hist) |-> !dout_valid)
        else $error("dout_valid was high within six cycles of cnt_rst.");

endmodule

bind rfi_power rfi_power_checker i_rfi_power_checker (
    .clk        (clk),
    .rst        (rst),
    .cnt_rst    (cnt_rst),
    .dout_valid (dout_valid),
    .warning    (warning)
);

//--- tb/tb_rfi_power.sv
`timescale 1ns/10ps

module tb_rfi_power import rfi_pkg::*; ();

    typedef struct packed {
        dout_t dout;
        logic  warn;
        chan_t chan;
        int    cyc;
    } exp_t;

    logic     clk;
    logic     rst;
    sample_t  sig_re, sig_im, ref_re, ref_im;
    logic     din_valid;
    logic     sync_in;
    acc_len_t acc_len;
    logic     cnt_rst;
    dout_t    dout;
    logic     dout_valid;
    logic     warning;

    int seed;
    int cycle;
    int n_checked;
    exp_t exp_q[$];

    // Reference model state.
    bit synced;
    bit primed;
    int spec_idx;
    int cur_len;
    int sig_sum [8];
    int ref_sum [8];

    rfi_power i_rfi_power (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) cycle <= cycle + 1;

    task automatic abort_run();
        $display("Regression failed");
        $fatal(1, "Stopped at the first error.");
    endtask

    function automatic int eff_len(acc_len_t len);
        return (len == 0) ? 1 : int'(len);
    endfunction

    // Shift, clamp to 12 bits, multiply, shift again.
    function automatic exp_t predict(int s_sum, int r_sum, int c, int cyc);
        exp_t e;
        int s_cast;
        int r_cast;
        s_cast = s_sum >> POST_ACC_SHIFT;
        r_cast = r_sum >> POST_ACC_SHIFT;
        e.warn = (s_cast > (1 << CAST_WIDTH) - 1) || (r_cast > (1 << CAST_WIDTH) - 1);
        if (s_cast > (1 << CAST_WIDTH) - 1) s_cast = (1 << CAST_WIDTH) - 1;
        if (r_cast > (1 << CAST_WIDTH) - 1) r_cast = (1 << CAST_WIDTH) - 1;
        e.dout = dout_t'((s_cast * r_cast) >> DOUT_SHIFT);
        e.chan = chan_t'(c);
        e.cyc = cyc;
        return e;
    endfunction

    task automatic model_sample(int c, sample_t sr, sample_t si, sample_t rr, sample_t ri);
        int sp;
        int rp;
        sp = int'(sr) * int'(sr) + int'(si) * int'(si);
        rp = int'(rr) * int'(rr) + int'(ri) * int'(ri);
        if (spec_idx == 0) begin
            if (primed) exp_q.push_back(predict(sig_sum[c], ref_sum[c], c, cycle + 6));
            sig_sum[c] = sp;
            ref_sum[c] = rp;
        end else begin
            sig_sum[c] += sp;
            ref_sum[c] += rp;
        end
        if (c == 7) begin
            if (spec_idx == 0) primed = 1'b1;
            if (spec_idx == cur_len - 1) begin
                spec_idx = 0;
                cur_len = eff_len(acc_len); // Next integration.
            end else begin
                spec_idx++;
            end
        end
    endtask

    task automatic idle_cycle();
        @(posedge clk);
        #1;
        din_valid = 1'b0;
        sync_in = 1'b0;
        cnt_rst = 1'b0;
        sig_re = sample_t'($random(seed));
        sig_im = sample_t'($random(seed));
        ref_re = sample_t'($random(seed));
        ref_im = sample_t'($random(seed));
    endtask

    task automatic send_sample(int c, sample_t sr, sample_t si, sample_t rr, sample_t ri);
        @(posedge clk);
        #1;
        din_valid = 1'b1;
        sync_in = 1'b0;
        cnt_rst = 1'b0;
        sig_re = sr;
        sig_im = si;
        ref_re = rr;
        ref_im = ri;
        model_sample(c, sr, si, rr, ri);
    endtask

    task automatic send_sync();
        @(posedge clk);
        #1;
        din_valid = 1'b0;
        sync_in = 1'b1;
        cnt_rst = 1'b0;
        if (!synced) begin
            synced = 1'b1; // Later pulses change nothing.
            spec_idx = 0;
            cur_len = eff_len(acc_len);
        end
    endtask

    task automatic send_spectrum(int max_gap, bit [7:0] sig_full, bit [7:0] ref_full,
                                 bit vary_len, int n_chan, bit with_sync);
        sample_t sr, si, rr, ri;
        int gap;
        if (with_sync) send_sync();
        for (int c = 0; c < n_chan; c++) begin
            gap = (max_gap == 0) ? 0 : ($random(seed) & 32'h7fffffff) % (max_gap + 1);
            repeat (gap) idle_cycle();
            sr = sig_full[c] ? 8'sh80 : sample_t'($random(seed));
            si = sig_full[c] ? 8'sh80 : sample_t'($random(seed));
            rr = ref_full[c] ? 8'sh80 : sample_t'($random(seed));
            ri = ref_full[c] ? 8'sh80 : sample_t'($random(seed));
            send_sample(c, sr, si, rr, ri);
            // Mid spectrum, far from the latch point of acc_len.
            if (vary_len && c == 3 && ($random(seed) & 3) == 0) begin
                acc_len = acc_len_t'(($random(seed) & 32'h7fffffff) % 7);
            end
        end
    endtask

    task automatic restart(acc_len_t len);
        @(posedge clk);
        #1;
        din_valid = 1'b0;
        cnt_rst = 1'b1;
        synced = 1'b0;
        primed = 1'b0;
        spec_idx = 0;
        // Results not yet out are flushed with the sums.
        while (exp_q.size() != 0 && exp_q[exp_q.size() - 1].cyc > cycle) begin
            exp_q.delete(exp_q.size() - 1);
        end
        idle_cycle();
        acc_len = len;
        send_sync();
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while (exp_q.size() != 0 && waited < 200) begin
            idle_cycle();
            waited++;
        end
        if (exp_q.size() != 0) begin
            $display("Timed out waiting for %0d pending outputs.", exp_q.size());
            abort_run();
        end
        repeat (8) idle_cycle();
    endtask

    task automatic check_output();
        exp_t e;
        assert (exp_q.size() != 0) else begin
            $display("dout_valid was high at cycle %0d with no result pending.", cycle);
            abort_run();
        end
        e = exp_q.pop_front();
        assert (cycle == e.cyc) else begin
            $display("Output for channel %0d came at cycle %0d, not at cycle %0d.",
                     e.chan, cycle, e.cyc);
            abort_run();
        end
        assert (dout == e.dout) else begin
            $display("ERROR dout: got %h, expected %h (channel %0d)", dout, e.dout, e.chan);
            abort_run();
        end
        assert (warning == e.warn) else begin
            $display("ERROR warning: got %h, expected %h (channel %0d)",
                     warning, e.warn, e.chan);
            abort_run();
        end
        n_checked++;
    endtask

    always @(negedge clk) begin
        if (!rst && dout_valid) check_output();
    end

    initial begin
        seed = 96823;
        cycle = 0;
        n_checked = 0;
        rst = 1'b1;
        sig_re = '0;
        sig_im = '0;
        ref_re = '0;
        ref_im = '0;
        din_valid = 1'b0;
        sync_in = 1'b0;
        acc_len = acc_len_t'(1);
        cnt_rst = 1'b0;
        synced = 1'b0;
        primed = 1'b0;
        spec_idx = 0;
        cur_len = 1;
        repeat (10) @(posedge clk);
        #1 rst = 1'b0;

        // One spectrum per integration, no gaps.
        restart(acc_len_t'(1));
        repeat (6) send_spectrum(0, 8'h00, 8'h00, 1'b0, 8, 1'b0);
        wait_drain();

        // Random lengths, gaps, stray syncs and acc_len changes.
        restart(acc_len_t'(1 + ($random(seed) & 32'h7fffffff) % 6));
        repeat (40) send_spectrum(3, 8'h00, 8'h00, 1'b1, 8, ($random(seed) & 7) == 0);
        wait_drain();

        // cnt_rst while products of the second integration are in flight.
        restart(acc_len_t'(3));
        repeat (3) send_spectrum(1, 8'h00, 8'h00, 1'b0, 8, 1'b0);
        send_spectrum(1, 8'h00, 8'h00, 1'b0, 5, 1'b0);
        restart(acc_len_t'(3));
        repeat (6) send_spectrum(1, 8'h00, 8'h00, 1'b0, 8, 1'b0);
        wait_drain();

        // Full scale on some channels saturates the casts.
        restart(acc_len_t'(40));
        repeat (41) send_spectrum(0, 8'h0F, 8'h3C, 1'b0, 8, 1'b0);
        wait_drain();

        assert (exp_q.size() == 0) else begin
            $display("%0d expected outputs never appeared.", exp_q.size());
            abort_run();
        end
        assert (n_checked > 0) else begin
            $display("No outputs were checked.");
            abort_run();
        end
        $display("Regression passed");
        $finish;
    end

endmodule

//--- sim.f
logic/rfi_pkg.sv
logic/pow_if.sv
logic/complex_power.sv
logic/spectrum_counter.sv
logic/acc_control.sv
logic/vector_accumulator.sv
logic/power_product.sv
logic/rfi_power.sv
tb/rfi_power_checker.sv
tb/tb_rfi_power.sv

//--- Makefile
TOP = tb_rfi_power

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f sim.f -o $(TOP)
	./obj_dir/$(TOP) | tee sim.log
	grep -q "Regression passed" sim.log

clean:
	rm -rf obj_dir sim.log
